// ==== icache_input.txt ====
# kind  address  expected_word  memory_requests  len
# memory word at A is (A xor 5a5a0000) plus A[5:2]
fetch 00001040 5A5A1040 1 15
fetch 0000107C 5A5A108B 0 0
fetch 00001044 5A5A1045 0 0
fetch 00003040 5A5A3040 1 15
fetch 00001040 5A5A1040 1 15
fetch A0000104 FA5A0105 1 0
fetch A0000104 FA5A0105 1 0
fetch A0001048 FA5A104A 1 0
fetch 00001058 5A5A105E 0 0
fetch 00000F24 5A5A0F2D 1 15
fetch 00000F00 5A5A0F00 0 0
fetch 00000F3C 5A5A0F4B 0 0
fetch 00000F10 5A5A0F14 0 0
fetch 00000F20 5A5A0F28 0 0
fetch 00000F30 5A5A0F3C 0 0
fetch 00000F04 5A5A0F05 0 0
fetch 00000F14 5A5A0F19 0 0
fetch 00000F28 5A5A0F32 0 0
fetch 00000F38 5A5A0F46 0 0
fetch 00000F08 5A5A0F0A 0 0
fetch 00000F18 5A5A0F1E 0 0
fetch 00000F2C 5A5A0F37 0 0
fetch 00000F0C 5A5A0F0F 0 0
fetch 00000F1C 5A5A0F23 0 0
fetch 00000F34 5A5A0F41 0 0
reset 00000000 00000000 0 0
fetch 00000F24 5A5A0F2D 1 15
fetch 00000F28 5A5A0F32 0 0

// ==== sources.f ====
icache_geom_pkg.sv
icache_bus_pkg.sv
icache_tag_array.sv
icache_refill_ctrl.sv
icache_data_bank.sv
icache_word_select.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then search the log for the pass line
cd "$(dirname "$0")" && rm -f sim.log &&
  verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_icache \
    -f sources.f -o tb_icache_sim > build.log 2>&1 &&
  ./obj_dir/tb_icache_sim > sim.log 2>&1 ||
  echo "build or run error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache
  import icache_geom_pkg::*, icache_bus_pkg::*;
();

  // memory model beat spacing is up to 3 cycles low plus the beat
  localparam int MAX_GAP      = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  // cycle budget of one test
  localparam int TEST_CYCLES  = WORDS_PER_LINE * MAX_GAP + 20;
  localparam logic [63:0] KIND_FETCH = {24'd0, "fetch"};
  localparam logic [63:0] KIND_RESET = {24'd0, "reset"};

  logic       clk;
  logic       rst;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  int         burst_count;
  addr_t      last_addr;
  logic [7:0] last_len;

  // one entry per test line
  logic  reset_kind [$];
  addr_t addrs      [$];
  word_t exp_words  [$];
  int    exp_counts [$];
  int    exp_lens   [$];
  logic  loaded = 1'b0;
  int    errors = 0;
  int    passed = 0;
  int    failed = 0;

  icache_top i_icache_top (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  tb_mem_model i_mem_model (
    .clk           (clk),
    .rst           (rst),
    .mem_req_i     (mem_req),
    .mem_rsp_o     (mem_rsp),
    .burst_count_o (burst_count),
    .last_addr_o   (last_addr),
    .last_len_o    (last_len)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_len(input string name, input beat_cnt_t got, input beat_cnt_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // line refill starts at the line and an uncached read at the word
  function automatic addr_t burst_addr(input addr_t a, input int len);
    burst_addr = (len == 0) ? {a[31:2], 2'b00} : {a[31:6], 6'b000000};
  endfunction

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [63:0] kind;
    addr_t       addr;
    word_t       word;
    int          cnt;
    int          len;
    fd = $fopen("icache_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open icache_input.txt, no tests run");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        // comment and blank lines
        if (line.len() < 2 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%s %h %h %d %d", kind, addr, word, cnt, len);
        if (n != 5 || (kind != KIND_FETCH && kind != KIND_RESET)) begin
          $display("unreadable test line: %s", line);
          errors++;
        end else begin
          reset_kind.push_back(kind == KIND_RESET);
          addrs.push_back(addr);
          exp_words.push_back(word);
          exp_counts.push_back(cnt);
          exp_lens.push_back(len);
        end
      end
      $fclose(fd);
    end
  endtask

  // both valids stay low from the first reset edge on even with a fetch held
  task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      if (fetch_rsp.valid !== 1'b0) begin
        $display("fetch response valid was not low during reset");
        errors++;
      end
      if (mem_req.valid !== 1'b0) begin
        $display("memory request valid was not low during reset");
        errors++;
      end
    end
    rst       = 1'b0;
    fetch_req = '0;
  endtask

  // reset lands while the refill of a held fetch is in flight
  task automatic reset_during_refill(input int t);
    int cycles;
    fetch_req.valid = 1'b1;
    fetch_req.addr  = addrs[t];
    cycles          = 0;
    while (mem_req.valid !== 1'b1 && cycles < TEST_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (mem_req.valid !== 1'b1) begin
      $display("no memory request for address %h before the reset", addrs[t]);
      errors++;
    end
    apply_reset();
  endtask

  // hold the fetch until the response pulse
  task automatic run_fetch(input int t);
    int    start_count;
    int    cycles;
    logic  got_rsp;
    word_t data;
    start_count     = burst_count;
    fetch_req.valid = 1'b1;
    fetch_req.addr  = addrs[t];
    got_rsp         = 1'b0;
    cycles          = 0;
    data            = '0;
    while (!got_rsp && cycles < TEST_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      if (fetch_rsp.valid === 1'b1) begin
        got_rsp = 1'b1;
        data    = fetch_rsp.data;
      end
    end
    // next fetch may follow in the response cycle
    fetch_req = '0;
    if (!got_rsp) begin
      $display("no fetch response for address %h within %0d cycles", addrs[t], TEST_CYCLES);
      errors++;
    end else begin
      check_word("fetch_rsp.data", data, exp_words[t]);
      check_count("memory requests", burst_count - start_count, exp_counts[t]);
      if (exp_counts[t] > 0) begin
        check_len("mem_req.len", beat_cnt_t'(last_len), beat_cnt_t'(exp_lens[t]));
        check_addr("mem_req.addr", last_addr, burst_addr(addrs[t], exp_lens[t]));
      end
    end
  endtask

  initial begin
    int errors_before;
    rst       = 1'b1;
    fetch_req = '0;
    load_tests();
    loaded = 1'b1;
    apply_reset();
    for (int t = 0; t < reset_kind.size(); t++) begin
      errors_before = errors;
      if (reset_kind[t]) begin
        reset_during_refill(t);
      end else begin
        run_fetch(t);
      end
      if (errors == errors_before) begin
        passed++;
        $display("test %0d %s %h: ok", t, reset_kind[t] ? "reset" : "fetch", addrs[t]);
      end else begin
        failed++;
        $display("test %0d %s %h: FAILED", t, reset_kind[t] ? "reset" : "fetch", addrs[t]);
      end
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             reset_kind.size(), passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // tests x (16 beats x max gap + 20) cycles
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = reset_kind.size() * (WORDS_PER_LINE * MAX_GAP + 20) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired after %0d ns, a fetch or burst never completed", limit_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model
  import icache_geom_pkg::*, icache_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  mem_req_t   mem_req_i,
  output mem_rsp_t   mem_rsp_o,
  output int         burst_count_o,
  output addr_t      last_addr_o,
  output logic [7:0] last_len_o
);

  // ready gap sequence
  int         seed = 5728;
  logic       active;
  int         beat;
  int         gap;
  logic       prev_valid;
  logic [7:0] prev_len;
  logic       rst_seen;

  // A xor 5a5a_0000, plus the word number inside the line
  function automatic word_t mem_word(input addr_t a);
    mem_word = (a ^ 32'h5A5A_0000) + word_t'(a[5:2]);
  endfunction

  initial begin
    mem_rsp_o     = '0;
    burst_count_o = 0;
    last_addr_o   = '0;
    last_len_o    = '0;
    active        = 1'b0;
    beat          = 0;
    gap           = 0;
    prev_valid    = 1'b0;
    prev_len      = '0;
    forever begin
      @(posedge clk);
      rst_seen = rst;
      #1;
      if (rst_seen) begin
        active    = 1'b0;
        beat      = 0;
        gap       = 0;
        mem_rsp_o = '0;
      end else begin
        // beat taken on the edge just passed
        if (prev_valid && mem_rsp_o.ready) begin
          if (beat == int'(prev_len)) begin
            active = 1'b0;
            beat   = 0;
          end else begin
            beat++;
          end
          // 0 to 3 cycles of ready low before the next beat
          gap = $random(seed) & 3;
        end
        // new request, one burst per rising valid
        if (mem_req_i.valid && !active) begin
          active        = 1'b1;
          beat          = 0;
          burst_count_o++;
          last_addr_o   = mem_req_i.addr;
          last_len_o    = mem_req_i.len;
        end
        if (active && gap == 0) begin
          mem_rsp_o.ready = 1'b1;
          mem_rsp_o.data  = mem_word(mem_req_i.addr + addr_t'(4 * beat));
        end else begin
          mem_rsp_o.ready = 1'b0;
          if (gap > 0) begin
            gap--;
          end
        end
      end
      // request as seen during the coming cycle
      prev_valid = mem_req_i.valid;
      prev_len   = mem_req_i.len;
    end
  end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/10ps

module icache_top
  import icache_geom_pkg::*, icache_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_req_i,
  output fetch_rsp_t fetch_rsp_o,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i
);

  // controller to tag array
  logic                hit;
  tag_t                lookup_tag;
  index_t              lookup_index;
  logic                tag_we;

  // controller to banks
  bank_wr_t            bank_wr;
  index_t              rd_index;

  // to word select
  logic [OFFSET_W-1:0] offset;
  logic                uncached_valid;
  word_t               uncached_word;
  logic                rsp_valid;
  bank_row_t           bank_rows [NUM_BANKS];

  icache_refill_ctrl i_refill_ctrl (
    .clk              (clk),
    .rst              (rst),
    .fetch_req_i      (fetch_req_i),
    .hit_i            (hit),
    .mem_rsp_i        (mem_rsp_i),
    .mem_req_o        (mem_req_o),
    .bank_wr_o        (bank_wr),
    .rd_index_o       (rd_index),
    .lookup_tag_o     (lookup_tag),
    .lookup_index_o   (lookup_index),
    .tag_we_o         (tag_we),
    .offset_o         (offset),
    .uncached_valid_o (uncached_valid),
    .uncached_word_o  (uncached_word),
    .rsp_valid_o      (rsp_valid)
  );

  icache_tag_array i_tag_array (
    .clk            (clk),
    .rst            (rst),
    .lookup_tag_i   (lookup_tag),
    .lookup_index_i (lookup_index),
    .we_i           (tag_we),
    .hit_o          (hit)
  );

  // bank b holds bytes 16b to 16b+15 of each line
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    icache_data_bank i_data_bank (
      .clk        (clk),
      .bank_id_i  (bank_sel_t'(b)),
      .wr_i       (bank_wr),
      .rd_index_i (rd_index),
      .rdata_o    (bank_rows[b])
    );
  end

  icache_word_select i_word_select (
    .bank_rows_i      (bank_rows),
    .offset_i         (offset),
    .uncached_valid_i (uncached_valid),
    .uncached_word_i  (uncached_word),
    .rsp_valid_i      (rsp_valid),
    .fetch_rsp_o      (fetch_rsp_o)
  );

endmodule

// ==== icache_word_select.sv ====
`timescale 1ns/10ps

module icache_word_select
  import icache_geom_pkg::*, icache_bus_pkg::*;
(
  input  bank_row_t           bank_rows_i [NUM_BANKS],
  input  logic [OFFSET_W-1:0] offset_i,
  input  logic                uncached_valid_i,
  input  word_t               uncached_word_i,
  input  logic                rsp_valid_i,
  output fetch_rsp_t          fetch_rsp_o
);

  bank_sel_t bank_sel;
  lane_sel_t lane_sel;
  bank_row_t row;
  word_t     cached_word;

  // offset 5:4 picks the bank, 3:2 the word lane
  // low two bits ignored, fetches are word aligned
  assign {bank_sel, lane_sel} = offset_i[OFFSET_W-1:2];

  // row from the bank holding this 16 byte slice
  assign row = bank_rows_i[bank_sel];

  // aligned word out of the row
  assign cached_word = row[lane_sel*WORD_W +: WORD_W];

  // uncached word only in the cycle after its beat
  assign fetch_rsp_o.valid = rsp_valid_i;
  assign fetch_rsp_o.data  = uncached_valid_i ? uncached_word_i : cached_word;

endmodule

// ==== icache_data_bank.sv ====
`timescale 1ns/10ps

module icache_data_bank
  import icache_geom_pkg::*, icache_bus_pkg::*;
(
  input  logic      clk,
  input  bank_sel_t bank_id_i,
  input  bank_wr_t  wr_i,
  input  index_t    rd_index_i,
  output bank_row_t rdata_o
);

  // 16 byte slice of every line
  bank_row_t mem_q [NUM_LINES];

  // registered read port
  bank_row_t rdata_q;

  // broadcast write addressed to this bank
  logic wr_hit;

  assign wr_hit = wr_i.en && (wr_i.bank == bank_id_i);

  always_ff @(posedge clk) begin
    // one 32 bit lane per beat, other lanes untouched
    if (wr_hit) begin
      mem_q[wr_i.index][wr_i.lane*WORD_W +: WORD_W] <= wr_i.data;
    end
    // data one cycle after the index
    rdata_q <= mem_q[rd_index_i];
  end

  assign rdata_o = rdata_q;

  // lane comes from the controller beat counter
  a_lane_known: assert property (@(posedge clk)
    wr_i.en |-> !$isunknown(wr_i.lane));

endmodule

// ==== icache_refill_ctrl.sv ====
`timescale 1ns/10ps

module icache_refill_ctrl
  import icache_geom_pkg::*, icache_bus_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  fetch_req_t          fetch_req_i,
  input  logic                hit_i,
  input  mem_rsp_t            mem_rsp_i,
  output mem_req_t            mem_req_o,
  output bank_wr_t            bank_wr_o,
  output index_t              rd_index_o,
  output tag_t                lookup_tag_o,
  output index_t              lookup_index_o,
  output logic                tag_we_o,
  output logic [OFFSET_W-1:0] offset_o,
  output logic                uncached_valid_o,
  output word_t               uncached_word_o,
  output logic                rsp_valid_o
);

  typedef enum logic [2:0] {
    RESET,
    IDLE,
    LOOKUP,
    LINE_REFILL,
    UNCACHED_READ
  } state_t;

  state_t              state_q;
  logic                mem_valid_q;
  beat_cnt_t           beat_q;
  logic                uncached_valid_q;
  // payload registers
  tag_t                tag_q;
  index_t              index_q;
  logic [OFFSET_W-1:0] offset_q;
  addr_t               mem_addr_q;
  logic [7:0]          mem_len_q;
  word_t               uncached_word_q;

  tag_t                fetch_tag;
  index_t              fetch_index;
  logic [OFFSET_W-1:0] fetch_offset;
  logic                uncached_region;
  logic                lookup_hit;
  logic                accept;
  logic                start_refill;
  logic                start_uncached;
  logic                beat_fire;
  logic                last_beat;

  assign {fetch_tag, fetch_index, fetch_offset} = fetch_req_i.addr;

  // top nibble of the registered address
  assign uncached_region = (tag_q[TAG_W-1 -: 4] == UNCACHED_REGION);
  assign lookup_hit      = (state_q == LOOKUP) && hit_i && !uncached_region;
  // new fetch taken in idle or right behind a hit
  assign accept          = fetch_req_i.valid && ((state_q == IDLE) || lookup_hit);
  assign start_refill    = (state_q == LOOKUP) && !uncached_region && !hit_i;
  assign start_uncached  = (state_q == LOOKUP) && uncached_region;
  assign beat_fire       = mem_valid_q && mem_rsp_i.ready;
  assign last_beat       = beat_fire && (beat_q == beat_cnt_t'(mem_len_q));

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= RESET;
      mem_valid_q      <= 1'b0;
      beat_q           <= '0;
      uncached_valid_q <= 1'b0;
    end else begin
      uncached_valid_q <= 1'b0;
      case (state_q)
        RESET: begin
          state_q <= IDLE;
        end
        IDLE: begin
          if (accept) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (start_uncached) begin
            state_q     <= UNCACHED_READ;
            mem_valid_q <= 1'b1;
          end else if (start_refill) begin
            state_q     <= LINE_REFILL;
            mem_valid_q <= 1'b1;
            beat_q      <= '0;
          end else if (!fetch_req_i.valid) begin
            // hit with nothing behind it
            state_q <= IDLE;
          end
        end
        LINE_REFILL: begin
          if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              // held fetch address hits on the next lookup
              mem_valid_q <= 1'b0;
              state_q     <= IDLE;
            end
          end
        end
        UNCACHED_READ: begin
          if (beat_fire) begin
            mem_valid_q      <= 1'b0;
            uncached_valid_q <= 1'b1;
            state_q          <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address fields, request and uncached word
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q    <= fetch_tag;
      index_q  <= fetch_index;
      offset_q <= fetch_offset;
    end
    if (start_refill) begin
      // whole line from its first byte
      mem_addr_q <= {tag_q, index_q, {OFFSET_W{1'b0}}};
      mem_len_q  <= LINE_BURST_LEN;
    end else if (start_uncached) begin
      // exact word that is never stored in the banks
      mem_addr_q <= {tag_q, index_q, offset_q[OFFSET_W-1:2], 2'b00};
      mem_len_q  <= SINGLE_BURST_LEN;
    end
    if ((state_q == UNCACHED_READ) && beat_fire) begin
      uncached_word_q <= mem_rsp_i.data;
    end
  end

  assign mem_req_o.valid = mem_valid_q;
  assign mem_req_o.addr  = mem_addr_q;
  assign mem_req_o.len   = mem_len_q;

  // beat n goes to bank n[3:2] and lane n[1:0]
  assign bank_wr_o.en    = (state_q == LINE_REFILL) && beat_fire;
  assign {bank_wr_o.bank, bank_wr_o.lane} = beat_q;
  assign bank_wr_o.index = index_q;
  assign bank_wr_o.data  = mem_rsp_i.data;

  // banks read the incoming index on the accepting edge
  assign rd_index_o       = accept ? fetch_index : index_q;
  assign lookup_tag_o     = tag_q;
  assign lookup_index_o   = index_q;
  assign tag_we_o         = (state_q == LINE_REFILL) && last_beat;
  assign offset_o         = offset_q;
  assign uncached_valid_o = uncached_valid_q;
  assign uncached_word_o  = uncached_word_q;
  assign rsp_valid_o      = lookup_hit || uncached_valid_q;

  // memory side sees one fixed request per burst
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_valid_q && $past(mem_valid_q) |-> $stable(mem_addr_q) && $stable(mem_len_q));

  // outside lookup a response only follows a single beat transfer
  a_rsp_source: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o |-> (state_q == LOOKUP) ||
                    $past(beat_fire && (mem_len_q == SINGLE_BURST_LEN)));

endmodule

// ==== icache_tag_array.sv ====
`timescale 1ns/10ps

module icache_tag_array
  import icache_geom_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  tag_t   lookup_tag_i,
  input  index_t lookup_index_i,
  input  logic   we_i,
  output logic   hit_o
);

  // one valid bit per line, cleared on reset
  logic [NUM_LINES-1:0] valid_q;

  // tag storage, only meaningful where valid is set
  tag_t tags_q [NUM_LINES];

  // current entry at the lookup index
  tag_t stored_tag;
  logic stored_valid;

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (we_i) begin
      // line fully refilled, entry becomes usable
      valid_q[lookup_index_i] <= 1'b1;
    end
  end

  // tag write at end of refill
  // same tag and index that missed in lookup
  always_ff @(posedge clk) begin
    if (we_i) begin
      tags_q[lookup_index_i] <= lookup_tag_i;
    end
  end

  // read side, purely combinational
  assign stored_tag   = tags_q[lookup_index_i];
  assign stored_valid = valid_q[lookup_index_i];

  // hit on the registered tag and index from the controller
  // a write lands one edge later, so a new entry hits next cycle
  assign hit_o = stored_valid && (stored_tag == lookup_tag_i);

endmodule

// ==== icache_bus_pkg.sv ====
package icache_bus_pkg;

  import icache_geom_pkg::*;

  // len field is beats minus one
  localparam logic [7:0] LINE_BURST_LEN = 8'(WORDS_PER_LINE - 1);
  localparam logic [7:0] SINGLE_BURST_LEN = 8'd0;

  // addr[31:28] of the uncached window
  localparam logic [3:0] UNCACHED_REGION = 4'hA;

  // fetch unit holds these until the response
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  // single cycle pulse back to fetch
  typedef struct packed {
    logic  valid;
    word_t data;
  } fetch_rsp_t;

  // held unchanged for the whole burst
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [7:0] len;
  } mem_req_t;

  // one beat per cycle with ready high
  typedef struct packed {
    logic  ready;
    word_t data;
  } mem_rsp_t;

  // broadcast to all banks, only the matching bank writes
  typedef struct packed {
    logic      en;
    bank_sel_t bank;
    index_t    index;
    lane_sel_t lane;
    word_t     data;
  } bank_wr_t;

endpackage

// ==== icache_geom_pkg.sv ====
package icache_geom_pkg;

  // 8 KB direct-mapped cache, 128 lines of 64 bytes
  // address = {tag, index, offset}

  // fetch and memory address width
  localparam int ADDR_W = 32;

  // byte offset inside a 64 byte line
  localparam int OFFSET_W = 6;

  // one index per line
  localparam int INDEX_W = 7;

  // whatever is left above index and offset
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  localparam int NUM_LINES = 1 << INDEX_W;

  // instruction word
  localparam int WORD_W = 32;

  // each bank row is a 16 byte slice of a line
  localparam int BANK_W = 128;

  // 512 bit line split over 128 bit banks
  localparam int NUM_BANKS = (8 << OFFSET_W) / BANK_W;

  // refill burst length in words
  localparam int WORDS_PER_LINE = (8 << OFFSET_W) / WORD_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BANK_W-1:0] bank_row_t;

  // offset bits 5:4
  typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

  // offset bits 3:2
  typedef logic [$clog2(BANK_W/WORD_W)-1:0] lane_sel_t;

  // beat number, upper bits pick the bank, lower bits the lane
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] beat_cnt_t;

endpackage
